//--- hw/gpu_sched_pkg.sv
package gpu_sched_pkg;

    // memory geometry
    localparam int MEM_DEPTH   = 1024;
    localparam int ADDR_W      = $clog2(MEM_DEPTH);
    localparam int WORD_W      = 16;                       // program word and message bus
    localparam int CORE_NUM    = 16;

    // task frame layout
    localparam int FRAME_WORDS = 16;
    localparam int OFF_W       = $clog2(FRAME_WORDS);      // word offset inside a frame
    localparam int FRAME_IDX_W = ADDR_W - OFF_W;           // frame index, upper address bits
    localparam int MASK_WORD   = 1;                        // core mask
    localparam int R0M_WORD    = 2;                        // r0 mask
    localparam int R0_FIRST    = 3;                        // r0 data runs 3..15

    // header word fields
    localparam int IFNUM_LSB   = 0;
    localparam int IFNUM_MSB   = 5;
    localparam int FENCE_LSB   = 6;
    localparam int FENCE_MSB   = 7;

    typedef logic [WORD_W-1:0]              word_t;
    typedef logic [ADDR_W-1:0]              addr_t;
    typedef logic [CORE_NUM-1:0]            core_mask_t;
    typedef logic [IFNUM_MSB-IFNUM_LSB:0]   if_count_t;

    typedef enum logic [1:0] {
        fence_none    = 2'd0,   // start at once
        fence_acquire = 2'd1,   // masked cores must be idle
        fence_release = 2'd2,   // all cores ready
        fence_end     = 2'd3    // program finished
    } fence_t;

    typedef enum logic [2:0] {
        st_idle,
        st_head,
        st_mask,
        st_wait,
        st_stream,
        st_done
    } sched_state_t;

endpackage

//--- hw/prog_mem.sv
`timescale 1ns/1ps

module prog_mem (
    input  logic                 clk,
    input  logic                 en,
    input  logic                 we,
    input  gpu_sched_pkg::addr_t addr,
    input  gpu_sched_pkg::word_t wdata,
    output gpu_sched_pkg::word_t rdata
);
    import gpu_sched_pkg::*;

    word_t mem [MEM_DEPTH];    // program storage, host loaded

    // single port, one access per cycle
    // rdata only moves on a read, so it holds across writes
    always_ff @(posedge clk) begin
        if (en) begin
            if (we) begin
                mem[addr] <= wdata;
            end else begin
                rdata <= mem[addr];   // registered read, one cycle latency
            end
        end
    end

endmodule

//--- hw/mem_arbiter.sv
`timescale 1ns/1ps

module mem_arbiter (
    input  logic                 clk,
    input  logic                 reset,
    // host side, always granted
    input  logic                 h_req,
    input  logic                 h_we,
    input  gpu_sched_pkg::addr_t h_addr,
    input  gpu_sched_pkg::word_t h_wdata,
    output logic                 h_rvalid,
    // scheduler side, reads only
    input  logic                 s_req,
    input  gpu_sched_pkg::addr_t s_addr,
    output logic                 s_gnt,
    output logic                 s_rvalid,
    // shared read data
    output gpu_sched_pkg::word_t rdata_out,
    // memory side
    output logic                 en,
    output logic                 we,
    output gpu_sched_pkg::addr_t addr,
    output gpu_sched_pkg::word_t wdata,
    input  gpu_sched_pkg::word_t rdata
);
    import gpu_sched_pkg::*;

    logic h_rd_q;   // last cycle's read belonged to host
    logic s_rd_q;   // ... or to scheduler

    // fixed priority, host first
    assign s_gnt = s_req && !h_req;

    assign en    = h_req || s_req;
    assign we    = h_req && h_we;               // scheduler never writes
    assign addr  = h_req ? h_addr : s_addr;
    assign wdata = h_wdata;

    // owner register, tags the data coming out next cycle
    always_ff @(posedge clk) begin
        if (reset) begin
            h_rd_q <= 1'b0;
            s_rd_q <= 1'b0;
        end else begin
            h_rd_q <= h_req && !h_we;
            s_rd_q <= s_gnt;
        end
    end

    assign h_rvalid  = h_rd_q;
    assign s_rvalid  = s_rd_q;
    assign rdata_out = rdata;   // valid only for the side flagged above

endmodule

//--- hw/host_port.sv
`timescale 1ns/1ps

module host_port (
    input  logic                 clk,
    input  logic                 reset,
    // host side
    input  logic                 host_load,
    input  logic                 host_wr,
    input  gpu_sched_pkg::word_t host_wdata,
    input  logic                 host_rd,
    input  gpu_sched_pkg::addr_t host_raddr,
    output logic                 host_rvalid,
    // arbiter side
    output logic                 h_req,
    output logic                 h_we,
    output gpu_sched_pkg::addr_t h_addr,
    output gpu_sched_pkg::word_t h_wdata,
    input  logic                 h_rvalid,
    // to scheduler
    output logic                 prog_loading
);
    import gpu_sched_pkg::*;

    logic  load_q;      // host_load delayed
    logic  load_rise;
    addr_t wr_addr;     // next load address
    addr_t wr_cur;      // address used by this cycle's write

    assign load_rise = host_load && !load_q;

    // a write in the rising cycle already goes to word 0
    assign wr_cur = load_rise ? '0 : wr_addr;

    always_ff @(posedge clk) begin
        if (reset) begin
            load_q  <= 1'b0;
            wr_addr <= '0;
        end else begin
            load_q <= host_load;
            if (host_wr) begin
                wr_addr <= wr_cur + 1'b1;   // auto increment
            end else if (load_rise) begin
                wr_addr <= '0;              // new program starts at 0
            end
        end
    end

    assign prog_loading = load_q;

    // write wins over a read in the same cycle
    assign h_req   = host_wr || host_rd;
    assign h_we    = host_wr;
    assign h_addr  = host_wr ? wr_cur : host_raddr;
    assign h_wdata = host_wdata;

    assign host_rvalid = h_rvalid;   // arbiter already tags ownership

endmodule

//--- hw/task_scheduler.sv
`timescale 1ns/1ps

module task_scheduler (
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      prog_loading,
    input  gpu_sched_pkg::core_mask_t core_ready,
    input  logic                      core_reading,
    // arbiter side
    output logic                      s_req,
    output gpu_sched_pkg::addr_t      s_addr,
    input  logic                      s_gnt,
    input  logic                      s_rvalid,
    input  gpu_sched_pkg::word_t      s_rdata,
    // message bus to cores
    output gpu_sched_pkg::word_t      mess_to_core,
    output logic                      core_mask_loading,
    output logic                      r0_mask_loading,
    output logic                      r0_loading,
    output logic                      instr_loading,
    output logic                      sched_done
);
    import gpu_sched_pkg::*;

    sched_state_t           state;
    logic [FRAME_IDX_W-1:0] frame;      // current frame index
    logic [OFF_W-1:0]       off;        // next word to read in that frame
    logic                   in_instr;   // walking instruction frames
    if_count_t              if_left;    // instruction frames still to go
    fence_t                 fence_q;    // fence of the current task
    core_mask_t             task_mask;  // word 1 of the current task
    logic                   prog_q;     // prog_loading delayed, for the falling edge

    // tag of the read in flight
    logic [OFF_W-1:0]       rd_off;
    logic                   rd_instr;

    logic                   rd_hdr;     // header word arriving
    logic                   rd_mask;    // core mask word arriving
    logic                   data_stb;   // arriving word goes straight to the bus
    core_mask_t             mask_now;
    logic                   fence_ok;
    logic                   send_mask;
    word_t                  mess_q;     // last word put on the bus

    assign rd_hdr   = s_rvalid && !rd_instr && rd_off == OFF_W'(0);
    assign rd_mask  = s_rvalid && !rd_instr && rd_off == OFF_W'(MASK_WORD);
    assign data_stb = s_rvalid && (rd_instr || rd_off >= OFF_W'(R0M_WORD));

    // mask lands in the first wait cycle, so forward it
    assign mask_now = rd_mask ? core_mask_t'(s_rdata) : task_mask;

    always_comb begin
        case (fence_q)
            fence_acquire: fence_ok = (mask_now & ~core_ready) == '0;  // no masked core busy
            fence_release: fence_ok = &core_ready;
            default:       fence_ok = 1'b1;
        endcase
    end

    assign send_mask = state == st_wait && fence_q != fence_end && fence_ok && core_reading;

    // reads only in fetch states, never while a fence is pending
    assign s_req  = (state == st_head || state == st_mask || state == st_stream)
                    && core_reading && !prog_loading;
    assign s_addr = {frame, off};

    always_ff @(posedge clk) begin
        if (reset) begin
            prog_q <= 1'b0;
        end else begin
            prog_q <= prog_loading;
        end
    end

    // frame walker
    always_ff @(posedge clk) begin
        if (reset || prog_loading) begin
            state    <= st_idle;    // restart from address 0
            frame    <= '0;
            off      <= '0;
            in_instr <= 1'b0;
            if_left  <= '0;
        end else begin
            if (rd_hdr) begin
                if_left <= if_count_t'(s_rdata[IFNUM_MSB:IFNUM_LSB]);
            end
            case (state)
                st_idle: begin
                    if (prog_q) begin
                        state <= st_head;   // program just loaded
                    end
                end
                st_head: begin
                    if (s_gnt) begin
                        state <= st_mask;
                        off   <= OFF_W'(MASK_WORD);
                    end
                end
                st_mask: begin
                    if (s_gnt) begin      // header is latched by now
                        state <= st_wait;
                        off   <= OFF_W'(R0M_WORD);
                    end
                end
                st_wait: begin
                    if (fence_q == fence_end) begin
                        state <= st_done;
                    end else if (send_mask) begin
                        state <= st_stream;
                    end
                end
                st_stream: begin
                    if (s_gnt) begin
                        if (off == '1) begin
                            frame <= frame + 1'b1;
                            off   <= '0;
                            if (if_left != '0) begin
                                if_left  <= if_left - 1'b1;
                                in_instr <= 1'b1;
                            end else begin
                                in_instr <= 1'b0;
                                state    <= st_head;   // next task
                            end
                        end else begin
                            off <= off + 1'b1;
                        end
                    end
                end
                default: ;   // st_done holds until the next load
            endcase
        end
    end

    // header fence
    always_ff @(posedge clk) begin
        if (reset) begin
            fence_q <= fence_none;
        end else if (rd_hdr) begin
            fence_q <= fence_t'(s_rdata[FENCE_MSB:FENCE_LSB]);
        end
    end

    always_ff @(posedge clk) begin
        if (rd_mask) begin
            task_mask <= core_mask_t'(s_rdata);
        end
        if (s_gnt) begin
            rd_off   <= off;
            rd_instr <= in_instr;
        end
    end

    // message bus
    always_ff @(posedge clk) begin
        if (reset) begin
            mess_q            <= '0;
            core_mask_loading <= 1'b0;
        end else begin
            core_mask_loading <= send_mask;   // mask goes out a cycle after the fence clears
            if (send_mask) begin
                mess_q <= word_t'(mask_now);
            end else if (data_stb) begin
                mess_q <= s_rdata;
            end
        end
    end

    // read data goes out in its arrival cycle
    assign mess_to_core    = data_stb ? s_rdata : mess_q;
    assign r0_mask_loading = s_rvalid && !rd_instr && rd_off == OFF_W'(R0M_WORD);
    assign r0_loading      = s_rvalid && !rd_instr && rd_off >= OFF_W'(R0_FIRST);
    assign instr_loading   = s_rvalid && rd_instr;
    assign sched_done      = state == st_done;

endmodule

//--- hw/gpu_sched_top.sv
`timescale 1ns/1ps

module gpu_sched_top (
    input  logic                      clk,
    input  logic                      reset,
    // host
    input  logic                      host_load,
    input  logic                      host_wr,
    input  gpu_sched_pkg::word_t      host_wdata,
    input  logic                      host_rd,
    input  gpu_sched_pkg::addr_t      host_raddr,
    output gpu_sched_pkg::word_t      host_rdata,
    output logic                      host_rvalid,
    // cores
    input  gpu_sched_pkg::core_mask_t core_ready,
    input  logic                      core_reading,
    output gpu_sched_pkg::word_t      mess_to_core,
    output logic                      core_mask_loading,
    output logic                      r0_mask_loading,
    output logic                      r0_loading,
    output logic                      instr_loading,
    output logic                      sched_done
);
    import gpu_sched_pkg::*;

    // host port to arbiter
    logic  h_req;
    logic  h_we;
    addr_t h_addr;
    word_t h_wdata;
    logic  h_rvalid;

    // scheduler to arbiter
    logic  s_req;
    addr_t s_addr;
    logic  s_gnt;
    logic  s_rvalid;

    // arbiter to memory
    logic  mem_en;
    logic  mem_we;
    addr_t mem_addr;
    word_t mem_wdata;
    word_t mem_rdata;

    word_t rdata_out;      // shared by both readers
    logic  prog_loading;

    host_port u_host_port (
        .clk          (clk),
        .reset        (reset),
        .host_load    (host_load),
        .host_wr      (host_wr),
        .host_wdata   (host_wdata),
        .host_rd      (host_rd),
        .host_raddr   (host_raddr),
        .host_rvalid  (host_rvalid),
        .h_req        (h_req),
        .h_we         (h_we),
        .h_addr       (h_addr),
        .h_wdata      (h_wdata),
        .h_rvalid     (h_rvalid),
        .prog_loading (prog_loading)
    );

    mem_arbiter u_mem_arbiter (
        .clk       (clk),
        .reset     (reset),
        .h_req     (h_req),
        .h_we      (h_we),
        .h_addr    (h_addr),
        .h_wdata   (h_wdata),
        .h_rvalid  (h_rvalid),
        .s_req     (s_req),
        .s_addr    (s_addr),
        .s_gnt     (s_gnt),
        .s_rvalid  (s_rvalid),
        .rdata_out (rdata_out),
        .en        (mem_en),
        .we        (mem_we),
        .addr      (mem_addr),
        .wdata     (mem_wdata),
        .rdata     (mem_rdata)
    );

    prog_mem u_prog_mem (
        .clk   (clk),
        .en    (mem_en),
        .we    (mem_we),
        .addr  (mem_addr),
        .wdata (mem_wdata),
        .rdata (mem_rdata)
    );

    task_scheduler u_task_scheduler (
        .clk               (clk),
        .reset             (reset),
        .prog_loading      (prog_loading),
        .core_ready        (core_ready),
        .core_reading      (core_reading),
        .s_req             (s_req),
        .s_addr            (s_addr),
        .s_gnt             (s_gnt),
        .s_rvalid          (s_rvalid),
        .s_rdata           (rdata_out),
        .mess_to_core      (mess_to_core),
        .core_mask_loading (core_mask_loading),
        .r0_mask_loading   (r0_mask_loading),
        .r0_loading        (r0_loading),
        .instr_loading     (instr_loading),
        .sched_done        (sched_done)
    );

    assign host_rdata = rdata_out;   // host_rvalid marks host-owned data

endmodule

//--- verif/sched_checker.sv
`timescale 1ns/1ps

module sched_checker (
    input logic                      clk,
    input logic                      reset,
    input logic                      core_reading,
    input gpu_sched_pkg::core_mask_t core_ready,
    input gpu_sched_pkg::fence_t     fence_q,
    input gpu_sched_pkg::word_t      mess_to_core,
    input logic                      core_mask_loading,
    input logic                      r0_mask_loading,
    input logic                      r0_loading,
    input logic                      instr_loading,
    input logic                      sched_done
);
    import gpu_sched_pkg::*;

    logic [3:0] stb;
    logic       any_stb;
    int         fail_cnt = 0;   // failed assertion count

    assign stb     = {instr_loading, r0_loading, r0_mask_loading, core_mask_loading};
    assign any_stb = |stb;

    strobe_onehot: assert property (@(posedge clk) disable iff (reset)
        $onehot0(stb))
        else begin
            fail_cnt++;
            $error("two kind strobes in one cycle");
        end

    // mask strobe is registered so the fence held one cycle earlier
    release_fence: assert property (@(posedge clk) disable iff (reset)
        core_mask_loading && fence_q == fence_release |-> $past(&core_ready))
        else begin
            fail_cnt++;
            $error("release mask sent while a core was not ready");
        end

    // mask itself is on the bus with its strobe
    acquire_fence: assert property (@(posedge clk) disable iff (reset)
        core_mask_loading && fence_q == fence_acquire
        |-> (mess_to_core & ~$past(core_ready)) == '0)
        else begin
            fail_cnt++;
            $error("acquire mask sent while a masked core was busy");
        end

    back_pressure: assert property (@(posedge clk) disable iff (reset)
        !core_reading && $past(!core_reading) |-> !any_stb)
        else begin
            fail_cnt++;
            $error("strobe after two cycles without core_reading");
        end

    done_quiet: assert property (@(posedge clk) disable iff (reset)
        sched_done |-> !any_stb)
        else begin
            fail_cnt++;
            $error("strobe after sched_done");
        end

endmodule

bind task_scheduler sched_checker u_sched_checker (
    .clk               (clk),
    .reset             (reset),
    .core_reading      (core_reading),
    .core_ready        (core_ready),
    .fence_q           (fence_q),
    .mess_to_core      (mess_to_core),
    .core_mask_loading (core_mask_loading),
    .r0_mask_loading   (r0_mask_loading),
    .r0_loading        (r0_loading),
    .instr_loading     (instr_loading),
    .sched_done        (sched_done)
);

//--- verif/tb_gpu_sched.sv
`timescale 1ns/1ps

module tb_gpu_sched;
    import gpu_sched_pkg::*;

    localparam int SEED      = 197;
    localparam int TASKS     = 5;
    localparam int RUN_LIMIT = 20000;   // cycles for the whole program
    localparam int IDLE_WAIT = 50;      // cycles for read data to drain
    localparam int DRAIN     = 16;      // quiet cycles watched after done

    // strobe kind codes in frame order
    localparam logic [1:0] K_MASK  = 2'd0;
    localparam logic [1:0] K_R0M   = 2'd1;
    localparam logic [1:0] K_R0    = 2'd2;
    localparam logic [1:0] K_INSTR = 2'd3;

    logic       clk          = 1'b0;
    logic       reset        = 1'b1;
    logic       host_load    = 1'b0;
    logic       host_wr      = 1'b0;
    word_t      host_wdata   = '0;
    logic       host_rd      = 1'b0;
    addr_t      host_raddr   = '0;
    core_mask_t core_ready   = '1;
    logic       core_reading = 1'b0;

    word_t host_rdata;
    logic  host_rvalid;
    word_t mess_to_core;
    logic  core_mask_loading;
    logic  r0_mask_loading;
    logic  r0_loading;
    logic  instr_loading;
    logic  sched_done;

    word_t      prog_img [MEM_DEPTH];   // host's copy of the program
    int         prog_len;
    logic [1:0] exp_kind [$];           // expected stream kind and word
    word_t      exp_word [$];
    word_t      rd_exp [$];             // read-back data still owed
    logic       rd_due    = 1'b0;       // a host read was taken last edge
    logic       run_cores = 1'b0;
    logic       done_seen = 1'b0;
    int         busy_cnt [CORE_NUM];    // cycles until a core is ready again
    int         errors        = 0;
    int         words_checked = 0;
    int         reads_checked = 0;
    logic [3:0] stb;
    logic [1:0] kind;

    always #4 clk = ~clk;   // 8 ns period

    gpu_sched_top DUT (
        .clk               (clk),
        .reset             (reset),
        .host_load         (host_load),
        .host_wr           (host_wr),
        .host_wdata        (host_wdata),
        .host_rd           (host_rd),
        .host_raddr        (host_raddr),
        .host_rdata        (host_rdata),
        .host_rvalid       (host_rvalid),
        .core_ready        (core_ready),
        .core_reading      (core_reading),
        .mess_to_core      (mess_to_core),
        .core_mask_loading (core_mask_loading),
        .r0_mask_loading   (r0_mask_loading),
        .r0_loading        (r0_loading),
        .instr_loading     (instr_loading),
        .sched_done        (sched_done)
    );

    task automatic add_word(input word_t w);
        prog_img[prog_len] = w;
        prog_len++;
    endtask

    task automatic expect_word(input logic [1:0] k, input word_t w);
        exp_kind.push_back(k);
        exp_word.push_back(w);
    endtask

    // fences none acquire release in turn then an end frame
    task automatic build_program();
        word_t hdr;
        word_t w;
        int    n;
        prog_len = 0;
        for (int t = 0; t < TASKS; t++) begin
            n = $urandom % 3;
            hdr = word_t'($urandom) & 16'hff00;   // upper byte is don't care
            hdr[FENCE_MSB:FENCE_LSB] = 2'(t % 3);
            hdr[IFNUM_MSB:IFNUM_LSB] = 6'(n);
            add_word(hdr);
            for (int i = 1; i < FRAME_WORDS * (n + 1); i++) begin
                w = word_t'($urandom);
                add_word(w);
                if (i == 1) begin
                    expect_word(K_MASK, w);
                end else if (i < R0_FIRST) begin
                    expect_word(K_R0M, w);
                end else if (i < FRAME_WORDS) begin
                    expect_word(K_R0, w);
                end else begin
                    expect_word(K_INSTR, w);   // instruction frames
                end
            end
        end
        hdr = '0;
        hdr[FENCE_MSB:FENCE_LSB] = 2'(fence_end);
        add_word(hdr);
        for (int i = 1; i < FRAME_WORDS; i++) begin
            add_word('0);
        end
    endtask

    task automatic load_program();
        @(posedge clk);
        host_load <= 1'b1;   // address restarts at 0
        for (int a = 0; a < prog_len; a++) begin
            @(posedge clk);
            host_wr    <= 1'b1;
            host_wdata <= prog_img[a];
        end
        @(posedge clk);
        host_wr   <= 1'b0;
        host_load <= 1'b0;
    endtask

    task automatic wait_reads_idle();
        int cycles;
        cycles = 0;
        while ((rd_exp.size() != 0 || rd_due || host_rd) && cycles < IDLE_WAIT) begin
            @(posedge clk);
            cycles++;
        end
        if (rd_exp.size() != 0 || rd_due || host_rd) begin
            errors++;
            $display("timeout: host read data still outstanding");
        end
    endtask

    // every written word read back before the cores start reading
    task automatic readback_all();
        for (int a = 0; a < prog_len; a++) begin
            @(posedge clk);
            host_rd    <= 1'b1;
            host_raddr <= addr_t'(a);
        end
        @(posedge clk);
        host_rd <= 1'b0;
        wait_reads_idle();
    endtask

    // host read bursts now and then while the scheduler runs
    task automatic run_program();
        int cycles;
        int burst;
        cycles = 0;
        burst  = 0;
        run_cores <= 1'b1;
        while (!sched_done && cycles < RUN_LIMIT) begin
            @(posedge clk);
            cycles++;
            if (burst == 0 && $urandom % 40 == 0) begin
                burst = 4 + $urandom % 5;
            end
            if (burst > 0) begin
                host_rd    <= 1'b1;
                host_raddr <= addr_t'($urandom % prog_len);
                burst--;
            end else begin
                host_rd <= 1'b0;
            end
        end
        host_rd <= 1'b0;
        if (!sched_done) begin
            errors++;
            $display("timeout: sched_done never rose within %0d cycles", RUN_LIMIT);
        end
    endtask

    // core model where ready bits drop at random and return within 20 cycles
    always @(posedge clk) begin
        if (reset) begin
            core_ready   <= '1;
            core_reading <= 1'b0;
            for (int i = 0; i < CORE_NUM; i++) begin
                busy_cnt[i] <= 0;
            end
        end else begin
            core_reading <= run_cores && ($urandom % 4 != 0);   // low about a quarter
            for (int i = 0; i < CORE_NUM; i++) begin
                if (busy_cnt[i] > 1) begin
                    busy_cnt[i] <= busy_cnt[i] - 1;
                end else if (busy_cnt[i] == 1) begin
                    busy_cnt[i]   <= 0;
                    core_ready[i] <= 1'b1;
                end else if ($urandom % 128 == 0) begin
                    core_ready[i] <= 1'b0;
                    busy_cnt[i]   <= 1 + $urandom % 20;
                end
            end
        end
    end

    // host read data due exactly one cycle after the strobe
    always @(posedge clk) begin
        if (reset) begin
            rd_due <= 1'b0;
        end else begin
            assert (host_rvalid === rd_due) else begin
                errors++;
                $display("Mismatch host_rvalid: got %h expected %h", host_rvalid, rd_due);
            end
            if (host_rvalid && rd_exp.size() != 0) begin
                assert (host_rdata === rd_exp[0]) else begin
                    errors++;
                    $display("Mismatch host_rdata: got %h expected %h", host_rdata, rd_exp[0]);
                end
                void'(rd_exp.pop_front());
                reads_checked++;
            end
            if (host_rd) begin
                rd_exp.push_back(prog_img[host_raddr]);
            end
            rd_due <= host_rd;
        end
    end

    // message bus against the expected list
    always @(posedge clk) begin
        if (!reset) begin
            stb = {instr_loading, r0_loading, r0_mask_loading, core_mask_loading};
            assert ($onehot0(stb)) else begin
                errors++;
                $display("more than one kind strobe high at %0t", $time);
            end
            if (stb != 4'b0) begin
                kind = stb[3] ? K_INSTR : stb[2] ? K_R0 : stb[1] ? K_R0M : K_MASK;
                if (exp_word.size() == 0) begin
                    errors++;
                    $display("strobe at %0t with no word left to expect", $time);
                end else begin
                    assert (kind == exp_kind[0]) else begin
                        errors++;
                        $display("Mismatch strobe kind: got %h expected %h", kind, exp_kind[0]);
                    end
                    assert (mess_to_core === exp_word[0]) else begin
                        errors++;
                        $display("Mismatch mess_to_core: got %h expected %h",
                                 mess_to_core, exp_word[0]);
                    end
                    void'(exp_kind.pop_front());
                    void'(exp_word.pop_front());
                    words_checked++;
                end
            end
            if (sched_done && !done_seen) begin
                done_seen <= 1'b1;
                assert (exp_word.size() == 0) else begin
                    errors++;
                    $display("sched_done rose with %0d words not yet sent", exp_word.size());
                end
            end
            if (done_seen) begin
                assert (sched_done) else begin
                    errors++;
                    $display("sched_done dropped after completion");
                end
            end
        end
    end

    initial begin
        void'($urandom(SEED));
        build_program();
        repeat (8) @(posedge clk);
        reset <= 1'b0;
        load_program();
        readback_all();
        run_program();
        wait_reads_idle();
        for (int i = 0; i < DRAIN; i++) begin
            @(posedge clk);   // nothing may move after done
        end
        if (exp_word.size() != 0) begin
            errors++;
            $display("%0d expected words never appeared on the bus", exp_word.size());
        end
        errors += DUT.u_task_scheduler.u_sched_checker.fail_cnt;   // bound checker failures
        $display("words checked %0d, reads checked %0d, errors %0d",
                 words_checked, reads_checked, errors);
        if (errors == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

//--- sources.f
hw/gpu_sched_pkg.sv
hw/prog_mem.sv
hw/mem_arbiter.sv
hw/host_port.sv
hw/task_scheduler.sv
hw/gpu_sched_top.sv
verif/sched_checker.sv
verif/tb_gpu_sched.sv

//--- Makefile
TOP  = tb_gpu_sched
LOG  = sim.log
SRCS = $(shell cat sources.f)

.PHONY: all compile run clean

all: run

compile: obj_dir/V$(TOP)

obj_dir/V$(TOP): sources.f $(SRCS)
	verilator --binary --timing --assert -Wno-fatal -j 0 --top-module $(TOP) -f sources.f

run: compile
	-./obj_dir/V$(TOP) | tee $(LOG)
	@if grep -q "Simulation completed successfully" $(LOG); then \
		echo "PASS"; \
	else \
		echo "FAIL"; exit 1; \
	fi

clean:
	rm -rf obj_dir $(LOG)
